//--- tb/stream_input.txt
# Columns: op (0 pass, 1 gray, 2 invert), width, height, pixel base, gap mode,
#   expected checksum, expected error code (bit 0 line length, bit 1 line count)
# Gap mode 1 adds random idle cycles on the input and sets the busy rate to 60
# Error code 1 sends a short first line, 2 sends a partial frame before this one
0 8 4 16 0 6096 0
1 4 2 251 0 1500 0
2 8 4 16 0 18384 0
1 8 4 100 0 14160 0
0 6 5 40 1 7605 0
2 6 5 40 1 15345 0
1 4 2 251 1 1500 0
0 8 4 16 0 5766 1
0 8 4 16 0 6096 2

//--- vlog.f
design/video_pkg.sv
design/apb_pkg.sv
design/apb_regs.sv
design/pixel_convert.sv
design/frame_sink.sv
design/video_capture_top.sv
tb/tb_video_capture.sv

//--- Makefile
TOP = tb_video_capture

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) \
		-Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

//--- tb/tb_video_capture.sv
// Self-checking capture testbench, run from the project root to find the frame data file
module tb_video_capture;

	localparam int half_period = 4;
	localparam int sample_delay = 2;
	localparam int busy_reset = 25;

	// One test frame as listed in the data file
	typedef struct packed {
		int op;
		int width;
		int height;
		int base;
		int gap;
		int checksum;
		int err_code;
	} frame_case_t;

	logic aclk = 1'b0;
	logic aresetn;
	apb_pkg::apb_req_t apb_req;
	apb_pkg::apb_rsp_t apb_rsp;
	video_pkg::stream_beat_t s_data;
	logic s_valid;
	logic s_ready;

	frame_case_t cases[$];
	integer seed = 51464;
	int total_beats = 0;
	int frames_done = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	video_capture_top #(
		.busy_rate_reset(busy_reset),
		.lfsr_seed(16'hace1)
	) dut (
		.aclk(aclk),
		.aresetn(aresetn),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.s_data(s_data),
		.s_valid(s_valid),
		.s_ready(s_ready)
	);

	always #half_period aclk = ~aclk;

	always @(posedge aclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			stop_on_failure();
		end
	end

	task automatic stop_on_failure();
		$display("TESTS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string what, input int got, input int expected);
		assert (got == expected) else begin
			$display("Fail at time %0t: %s is %0d, expected %0d", $time, what, got, expected);
			stop_on_failure();
		end
	endtask

	// ----------------------------------------
	// Reference model of the pixel rules
	// ----------------------------------------

	function automatic logic [23:0] pixel_data(input int base, input int index);
		logic [23:0] data;
		for (int c = 0; c < video_pkg::comp_num; c++) begin
			data[c*video_pkg::comp_width +: video_pkg::comp_width] = 8'((base + 3*index + c) % 256);
		end
		return data;
	endfunction

	function automatic logic [23:0] convert_pixel(input logic [23:0] data, input int op);
		int red;
		int green;
		int blue;
		logic [7:0] luma;
		red = int'(data[7:0]);
		green = int'(data[15:8]);
		blue = int'(data[23:16]);
		luma = 8'((red + 2*green + blue) / 4);
		if (op == int'(video_pkg::op_gray)) begin
			return {luma, luma, luma};
		end else if (op == int'(video_pkg::op_invert)) begin
			return {8'(255 - blue), 8'(255 - green), 8'(255 - red)};
		end
		return data;
	endfunction

	function automatic int pixel_sum(input logic [23:0] data);
		return int'(data[7:0]) + int'(data[15:8]) + int'(data[23:16]);
	endfunction

	// ----------------------------------------
	// APB and stream drivers
	// ----------------------------------------

	// All drivers start and end on a falling edge
	task automatic apb_access(input int addr, input int data, input logic write,
			output int rdata, output logic err);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = write;
		apb_req.paddr = 8'(addr);
		apb_req.pwdata = 32'(data);
		@(negedge aclk);
		apb_req.penable = 1'b1;
		#sample_delay;
		rdata = int'(apb_rsp.prdata);
		err = apb_rsp.pslverr;
		check_value("pready", int'(apb_rsp.pready), 1);
		@(negedge aclk);
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b0;
	endtask

	task automatic write_checked(input int addr, input int data, input string what);
		int unused;
		logic err;
		apb_access(addr, data, 1'b1, unused, err);
		check_value({what, " pslverr"}, int'(err), 0);
	endtask

	task automatic read_expect(input int addr, input int expected, input string what);
		int value;
		logic err;
		apb_access(addr, 0, 1'b0, value, err);
		check_value({what, " pslverr"}, int'(err), 0);
		check_value(what, value, expected);
	endtask

	task automatic send_beat(input video_pkg::stream_beat_t beat);
		logic taken;
		s_data = beat;
		s_valid = 1'b1;
		taken = 1'b0;
		// s_ready only moves on the rising edge, so mid low phase is safe
		while (!taken) begin
			#sample_delay;
			taken = s_ready;
			@(negedge aclk);
		end
		s_valid = 1'b0;
	endtask

	// Sends the frame and returns the checksum the sink should report for it
	task automatic send_frame(input frame_case_t fc, input int lines, input logic short_first,
			input logic change_op, output int sum);
		video_pkg::stream_beat_t beat;
		int index;
		int len;
		int idle;
		sum = 0;
		index = 0;
		for (int y = 0; y < lines; y++) begin
			len = (short_first && y == 0) ? fc.width - 1 : fc.width;
			for (int x = 0; x < len; x++) begin
				// Op change mid frame must wait for the next tuser
				if (change_op && index == fc.width * fc.height / 2) begin
					write_checked(int'(apb_pkg::reg_op), (fc.op + 1) % 3, "mid-frame op write");
				end
				if (fc.gap != 0) begin
					idle = $random(seed) & 3;
					repeat (idle) @(negedge aclk);
				end
				beat.tdata = pixel_data(fc.base, index);
				beat.tuser = (index == 0);
				beat.tlast = (x == len - 1);
				send_beat(beat);
				sum = (sum + pixel_sum(convert_pixel(beat.tdata, fc.op))) % 65536;
				index++;
			end
		end
	endtask

	// ----------------------------------------
	// Test sequences
	// ----------------------------------------

	task automatic load_cases();
		int fd;
		int count;
		int field[7];
		string line;
		frame_case_t fc;
		fd = $fopen("tb/stream_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file tb/stream_input.txt");
			stop_on_failure();
		end
		while (!$feof(fd)) begin
			line = "";
			count = $fgets(line, fd);
			if (count > 0 && line[0] != "#") begin
				count = $sscanf(line, "%d %d %d %d %d %d %d", field[0], field[1], field[2],
					field[3], field[4], field[5], field[6]);
				if (count == 7) begin
					fc = '{field[0], field[1], field[2], field[3], field[4], field[5], field[6]};
					cases.push_back(fc);
					total_beats += fc.width * fc.height - (fc.err_code == 1 ? 1 : 0);
					total_beats += (fc.err_code == 2) ? (fc.height - 1) * fc.width : 0;
				end
			end
		end
		$fclose(fd);
		if (cases.size() == 0) begin
			$display("The stimulus file holds no test frames");
			stop_on_failure();
		end
	endtask

	task automatic check_apb_map();
		int value;
		logic err;
		check_value("s_ready after reset", int'(s_ready), 1);
		read_expect(int'(apb_pkg::reg_busy_rate), busy_reset, "busy rate after reset");
		read_expect(int'(apb_pkg::reg_frame_count), 0, "frame count after reset");
		read_expect(int'(apb_pkg::reg_checksum), 0, "checksum after reset");
		read_expect(int'(apb_pkg::reg_error), 0, "error flags after reset");
		apb_access(int'(apb_pkg::reg_frame_count), 7, 1'b1, value, err);
		check_value("pslverr on frame count write", int'(err), 1);
		apb_access(int'(apb_pkg::reg_checksum), 32'h1234, 1'b1, value, err);
		check_value("pslverr on checksum write", int'(err), 1);
		apb_access(8'h1C, 0, 1'b0, value, err);
		check_value("pslverr on unmapped read", int'(err), 1);
		apb_access(8'h40, 0, 1'b1, value, err);
		check_value("pslverr on unmapped write", int'(err), 1);
		read_expect(int'(apb_pkg::reg_frame_count), 0, "frame count after refused write");
	endtask

	task automatic run_case(input frame_case_t fc);
		int busy;
		int model_sum;
		int discard;
		int value;
		logic err;
		busy = (fc.gap != 0) ? 60 : 0;
		write_checked(int'(apb_pkg::reg_width), fc.width, "width write");
		write_checked(int'(apb_pkg::reg_height), fc.height, "height write");
		write_checked(int'(apb_pkg::reg_op), fc.op, "op write");
		write_checked(int'(apb_pkg::reg_busy_rate), busy, "busy rate write");
		read_expect(int'(apb_pkg::reg_width), fc.width, "width readback");
		read_expect(int'(apb_pkg::reg_height), fc.height, "height readback");
		read_expect(int'(apb_pkg::reg_op), fc.op, "op readback");
		read_expect(int'(apb_pkg::reg_busy_rate), busy, "busy rate readback");
		// Cut frame one line short so the next tuser comes early
		if (fc.err_code == 2) begin
			send_frame(fc, fc.height - 1, 1'b0, 1'b0, discard);
		end
		send_frame(fc, fc.height, fc.err_code == 1, 1'b1, model_sum);
		frames_done++;
		value = 0;
		while (value < frames_done) begin
			apb_access(int'(apb_pkg::reg_frame_count), 0, 1'b0, value, err);
		end
		check_value("frame count", value, frames_done);
		check_value("model checksum against data file", model_sum, fc.checksum);
		read_expect(int'(apb_pkg::reg_checksum), model_sum, "checksum");
		read_expect(int'(apb_pkg::reg_error), fc.err_code, "error flags");
		if (fc.err_code != 0) begin
			write_checked(int'(apb_pkg::reg_error), 3, "error clear write");
			read_expect(int'(apb_pkg::reg_error), 0, "error flags after clear");
		end
	endtask

	initial begin
		aresetn = 1'b0;
		apb_req = '0;
		s_data = '0;
		s_valid = 1'b0;
		load_cases();
		cycle_limit = 40 * total_beats + 2000;
		repeat (3) @(negedge aclk);
		aresetn = 1'b1;
		check_apb_map();
		foreach (cases[n]) begin
			run_case(cases[n]);
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- design/video_capture_top.sv
// Capture subsystem top level joining the APB register block, pixel conversion and frame sink
module video_capture_top #(
	parameter int unsigned busy_rate_reset = 0,
	parameter logic [15:0] lfsr_seed = 16'hace1
) (
	input logic aclk,
	input logic aresetn,
	input apb_pkg::apb_req_t apb_req,
	output apb_pkg::apb_rsp_t apb_rsp,
	input video_pkg::stream_beat_t s_data,
	input logic s_valid,
	output logic s_ready
);

	// Configuration from the register block
	logic [video_pkg::dim_width-1:0] width;
	logic [video_pkg::dim_width-1:0] height;
	video_pkg::pixel_op_e op;
	logic [6:0] busy_rate;
	logic error_clear;

	// Status back from the sink
	video_pkg::sink_status_t status;

	// Stream between conversion and sink
	video_pkg::stream_beat_t m_data;
	logic m_valid;
	logic m_ready;

	apb_regs #(
		.busy_rate_reset(busy_rate_reset)
	) u_regs (
		.aclk(aclk),
		.aresetn(aresetn),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.status(status),
		.width(width),
		.height(height),
		.op(op),
		.busy_rate(busy_rate),
		.error_clear(error_clear)
	);

	pixel_convert u_convert (
		.aclk(aclk),
		.aresetn(aresetn),
		.op(op),
		.s_data(s_data),
		.s_valid(s_valid),
		.s_ready(s_ready),
		.m_data(m_data),
		.m_valid(m_valid),
		.m_ready(m_ready)
	);

	frame_sink #(
		.lfsr_seed(lfsr_seed)
	) u_sink (
		.aclk(aclk),
		.aresetn(aresetn),
		.width(width),
		.height(height),
		.busy_rate(busy_rate),
		.error_clear(error_clear),
		.s_data(m_data),
		.s_valid(m_valid),
		.s_ready(m_ready),
		.status(status)
	);

endmodule

//--- design/frame_sink.sv
// Stream end stage with LFSR back-pressure, geometry checks, checksum and frame counting
module frame_sink #(
	parameter logic [15:0] lfsr_seed = 16'hace1
) (
	input logic aclk,
	input logic aresetn,
	input logic [video_pkg::dim_width-1:0] width,
	input logic [video_pkg::dim_width-1:0] height,
	input logic [6:0] busy_rate,
	input logic error_clear,
	input video_pkg::stream_beat_t s_data,
	input logic s_valid,
	output logic s_ready,
	output video_pkg::sink_status_t status
);

	logic [15:0] lfsr;
	logic [6:0] lfsr_mod;
	logic fire;
	logic [video_pkg::dim_width-1:0] x_q;
	logic [video_pkg::dim_width-1:0] y_q;
	logic [video_pkg::dim_width-1:0] beat_x;
	logic [video_pkg::dim_width-1:0] beat_y;
	logic last_x;
	logic frame_end;
	logic in_frame;
	logic first_beat;
	logic [video_pkg::count_width-1:0] sum_q;
	logic [video_pkg::count_width-1:0] beat_sum;
	logic [video_pkg::count_width-1:0] sum_next;

	// ----------------------------------------
	// Back-pressure
	// ----------------------------------------

	// Fibonacci LFSR, taps 16 14 13 11
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			lfsr <= lfsr_seed;
		end else begin
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		end
	end

	assign lfsr_mod = 7'(lfsr % 16'd100);
	// Rate 0 never stalls
	assign s_ready = (lfsr_mod >= busy_rate);
	assign fire = s_valid && s_ready;

	// ----------------------------------------
	// Position tracking
	// ----------------------------------------

	// tuser restarts the frame at the current beat
	assign beat_x = s_data.tuser ? '0 : x_q;
	assign beat_y = s_data.tuser ? '0 : y_q;
	assign last_x = (beat_x == width - 1'b1);
	assign frame_end = s_data.tlast && (beat_y == height - 1'b1);

	always_comb begin
		beat_sum = '0;
		for (int i = 0; i < video_pkg::comp_num; i++) begin
			beat_sum = beat_sum +
				16'(s_data.tdata[i*video_pkg::comp_width +: video_pkg::comp_width]);
		end
	end

	assign sum_next = (s_data.tuser ? '0 : sum_q) + beat_sum;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			x_q <= '0;
			y_q <= '0;
			sum_q <= '0;
			in_frame <= 1'b0;
			first_beat <= 1'b1;
		end else if (fire) begin
			first_beat <= 1'b0;
			sum_q <= sum_next;
			in_frame <= !frame_end && (in_frame || s_data.tuser);
			if (s_data.tlast) begin
				x_q <= '0;
				y_q <= frame_end ? '0 : beat_y + 1'b1;
			end else begin
				x_q <= beat_x + 1'b1;
				y_q <= beat_y;
			end
		end
	end

	// ----------------------------------------
	// Status and sticky errors
	// ----------------------------------------

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			status <= '0;
		end else begin
			status.frame_done <= 1'b0;
			if (error_clear) begin
				status.line_len_err <= 1'b0;
				status.line_cnt_err <= 1'b0;
			end
			if (fire) begin
				// tlast must land exactly on the last column
				if (s_data.tlast != last_x) begin
					status.line_len_err <= 1'b1;
				end
				// New frame before the previous one reached height lines
				if (s_data.tuser && in_frame) begin
					status.line_cnt_err <= 1'b1;
				end
				if (frame_end) begin
					status.frame_count <= status.frame_count + 1'b1;
					status.checksum <= sum_next;
					status.frame_done <= 1'b1;
				end
			end
		end
	end

	a_tuser_at_line_start: assert property (@(posedge aclk) disable iff (!aresetn)
		fire && s_data.tuser |-> (x_q == '0) || first_beat);

endmodule

//--- design/pixel_convert.sv
// Stream stage with one output register that applies the per-frame pass, gray or invert operation
module pixel_convert (
	input logic aclk,
	input logic aresetn,
	input video_pkg::pixel_op_e op,
	input video_pkg::stream_beat_t s_data,
	input logic s_valid,
	output logic s_ready,
	output video_pkg::stream_beat_t m_data,
	output logic m_valid,
	input logic m_ready
);

	video_pkg::pixel_op_e op_q;
	video_pkg::pixel_op_e beat_op;
	logic s_fire;

	// Applies the operation to the color data, tuser and tlast pass through
	function automatic video_pkg::stream_beat_t convert_beat(
		input video_pkg::stream_beat_t beat,
		input video_pkg::pixel_op_e sel
	);
		video_pkg::stream_beat_t result;
		logic [video_pkg::comp_width+1:0] red;
		logic [video_pkg::comp_width+1:0] green;
		logic [video_pkg::comp_width+1:0] blue;
		logic [video_pkg::comp_width+1:0] luma;
		result = beat;
		red = {2'b00, beat.tdata[0 +: video_pkg::comp_width]};
		green = {2'b00, beat.tdata[video_pkg::comp_width +: video_pkg::comp_width]};
		blue = {2'b00, beat.tdata[2*video_pkg::comp_width +: video_pkg::comp_width]};
		// Max sum is 4 * 255, so the shift always fits in one component
		luma = red + (green << 1) + blue;
		case (sel)
			video_pkg::op_gray: begin
				result.tdata = {video_pkg::comp_num{luma[video_pkg::comp_width+1:2]}};
			end
			video_pkg::op_invert: result.tdata = ~beat.tdata;
			default: result.tdata = beat.tdata;
		endcase
		return result;
	endfunction

	// ----------------------------------------
	// Handshake
	// ----------------------------------------

	// Accept when empty or when the held beat leaves this cycle
	assign s_ready = !m_valid || m_ready;
	assign s_fire = s_valid && s_ready;

	// The frame start beat already uses the new operation
	assign beat_op = s_data.tuser ? op : op_q;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			op_q <= video_pkg::op_pass;
		end else if (s_fire && s_data.tuser) begin
			op_q <= op;
		end
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			m_valid <= 1'b0;
		end else if (s_ready) begin
			m_valid <= s_valid;
		end
	end

	always_ff @(posedge aclk) begin
		if (s_fire) begin
			m_data <= convert_beat(s_data, beat_op);
		end
	end

	a_hold_stable: assert property (@(posedge aclk) disable iff (!aresetn)
		m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

//--- design/apb_regs.sv
// APB slave holding the capture configuration and returning the frame sink status on read
module apb_regs #(
	parameter int unsigned busy_rate_reset = 0
) (
	input logic aclk,
	input logic aresetn,
	input apb_pkg::apb_req_t apb_req,
	output apb_pkg::apb_rsp_t apb_rsp,
	input video_pkg::sink_status_t status,
	output logic [video_pkg::dim_width-1:0] width,
	output logic [video_pkg::dim_width-1:0] height,
	output video_pkg::pixel_op_e op,
	output logic [6:0] busy_rate,
	output logic error_clear
);

	apb_pkg::reg_addr_e addr;
	logic access;
	logic mapped;
	logic read_only;
	logic wr_en;
	logic [apb_pkg::data_width-1:0] rdata;

	assign addr = apb_pkg::reg_addr_e'(apb_req.paddr);
	assign access = apb_req.psel && apb_req.penable;

	// ----------------------------------------
	// Address decode and read mux
	// ----------------------------------------

	always_comb begin
		rdata = '0;
		mapped = 1'b1;
		read_only = 1'b0;
		case (addr)
			apb_pkg::reg_width: rdata = 32'(width);
			apb_pkg::reg_height: rdata = 32'(height);
			apb_pkg::reg_op: rdata = 32'(op);
			apb_pkg::reg_busy_rate: rdata = 32'(busy_rate);
			apb_pkg::reg_frame_count: begin
				rdata = 32'(status.frame_count);
				read_only = 1'b1;
			end
			apb_pkg::reg_checksum: begin
				rdata = 32'(status.checksum);
				read_only = 1'b1;
			end
			apb_pkg::reg_error: rdata = {30'd0, status.line_cnt_err, status.line_len_err};
			default: mapped = 1'b0;
		endcase
	end

	// No wait states, errors only in the access phase
	assign apb_rsp.pready = 1'b1;
	assign apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && read_only));
	assign apb_rsp.prdata = (access && !apb_req.pwrite) ? rdata : '0;

	assign wr_en = access && apb_req.pwrite && mapped && !read_only;

	// ----------------------------------------
	// Configuration registers
	// ----------------------------------------

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			width <= '0;
			height <= '0;
			op <= video_pkg::op_pass;
			busy_rate <= 7'(busy_rate_reset);
			error_clear <= 1'b0;
		end else begin
			error_clear <= 1'b0;
			if (wr_en) begin
				case (addr)
					apb_pkg::reg_width: width <= apb_req.pwdata[video_pkg::dim_width-1:0];
					apb_pkg::reg_height: height <= apb_req.pwdata[video_pkg::dim_width-1:0];
					apb_pkg::reg_op: op <= video_pkg::pixel_op_e'(apb_req.pwdata[1:0]);
					apb_pkg::reg_busy_rate: busy_rate <= apb_req.pwdata[6:0];
					// One pulse clears both sticky flags in the sink
					apb_pkg::reg_error: error_clear <= |apb_req.pwdata[1:0];
					default: ;
				endcase
			end
		end
	end

	// Every access phase follows exactly one setup cycle
	a_apb_phase: assert property (@(posedge aclk) disable iff (!aresetn)
		apb_req.penable |-> apb_req.psel && $past(apb_req.psel && !apb_req.penable));

endmodule

//--- design/apb_pkg.sv
// APB request and response records and the register map of the capture block
package apb_pkg;

	localparam int addr_width = 8;
	localparam int data_width = 32;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [addr_width-1:0] paddr;
		logic [data_width-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [data_width-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// ----------------------------------------
	// Register offsets
	// ----------------------------------------

	typedef enum logic [addr_width-1:0] {
		reg_width = 8'h00,
		reg_height = 8'h04,
		reg_op = 8'h08,
		reg_busy_rate = 8'h0C,
		// Read only from here
		reg_frame_count = 8'h10,
		reg_checksum = 8'h14,
		// Bit 0 line length, bit 1 line count, write 1s to clear
		reg_error = 8'h18
	} reg_addr_e;

endpackage

//--- design/video_pkg.sv
// Video stream beat, pixel operation and sink status types for the capture stages and testbench
package video_pkg;

	// ----------------------------------------
	// Pixel format
	// ----------------------------------------

	// Component 0 (low bits) is red, 1 is green, 2 is blue
	localparam int comp_width = 8;
	localparam int comp_num = 3;
	localparam int data_width = comp_width * comp_num;

	// Frame geometry and status counters
	localparam int dim_width = 12;
	localparam int count_width = 16;

	typedef enum logic [1:0] {
		op_pass = 2'd0,
		op_gray = 2'd1,
		op_invert = 2'd2
	} pixel_op_e;

	// ----------------------------------------
	// Stream and status records
	// ----------------------------------------

	typedef struct packed {
		logic [data_width-1:0] tdata;
		logic tuser;
		logic tlast;
	} stream_beat_t;

	typedef struct packed {
		logic [count_width-1:0] frame_count;
		logic [count_width-1:0] checksum;
		logic line_len_err;
		logic line_cnt_err;
		logic frame_done;
	} sink_status_t;

endpackage
